// File: verilog/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

// File: verilog/rv_pkg.sv
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OP     = 7'b011_0011,
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    BRANCH = 7'b110_0011,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm_11_0;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    opcode_e               opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    opcode_e               opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [`RV_REG_AW-1:0] rd;
    opcode_e               opcode;
  } j_fmt_t;

  // one fetched word, viewed per format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

  typedef enum logic [1:0] {
    SRC_A_RS1  = 2'd0,
    SRC_A_PC   = 2'd1,
    SRC_A_ZERO = 2'd2  // lui
  } src_a_e;

  typedef enum logic {
    SRC_B_IMM = 1'b0,
    SRC_B_RS2 = 1'b1
  } src_b_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LINK = 2'd1,  // pc + 4 for jal/jalr
    WB_LOAD = 2'd2
  } wb_sel_e;

endpackage

`default_nettype wire

// File: verilog/exec_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

// decoded control, all valid in the fetch cycle
interface exec_ctrl_if;
  logic [`RV_XLEN-1:0] imm;
  rv_pkg::src_a_e      src_a;
  rv_pkg::src_b_e      src_b;
  logic                sub;
  logic                is_branch;
  logic                is_jump;
  logic [2:0]          funct3;  // branch condition or access size
  logic                mem_read;
  logic                mem_write;
  rv_pkg::wb_sel_e     wb_sel;
  logic                reg_write;

  modport decoder (
    output imm, src_a, src_b, sub, is_branch, is_jump, funct3,
           mem_read, mem_write, wb_sel, reg_write
  );

  modport execute (input imm, src_a, src_b, sub, is_branch, is_jump, funct3);

  modport lsu (input funct3, mem_read, mem_write, wb_sel);
endinterface

`default_nettype wire

// File: verilog/pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module pc_unit (
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                halt,
  input  wire logic                redirect,
  input  wire logic [`RV_XLEN-1:0] target,
  output logic      [`RV_XLEN-1:0] pc,
  output logic      [`RV_XLEN-1:0] pc_plus4
);

  logic [`RV_XLEN-1:0] next_pc;

  assign pc_plus4 = pc + 4;  // static next pc
  assign next_pc  = redirect ? target : pc_plus4;

  // ebreak keeps the core parked on its own address
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module inst_decoder (
  input  rv_pkg::inst_t         inst,
  output logic [`RV_REG_AW-1:0] rs1_addr,
  output logic [`RV_REG_AW-1:0] rs2_addr,
  output logic [`RV_REG_AW-1:0] rd_addr,
  output logic                  halt,
  exec_ctrl_if.decoder          ctrl
);

  rv_pkg::opcode_e     opcode;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                is_add_sub;
  logic                is_ebreak;

  // register fields sit at the same place in every format
  assign opcode   = inst.r_fmt.opcode;
  assign rs1_addr = inst.r_fmt.rs1;
  assign rs2_addr = inst.r_fmt.rs2;
  assign rd_addr  = inst.r_fmt.rd;

  assign ctrl.funct3 = inst.r_fmt.funct3;

  assign imm_i = {{(`RV_XLEN-12){inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
  assign imm_s = {{(`RV_XLEN-12){inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                  inst.s_fmt.imm_4_0};
  assign imm_b = {{(`RV_XLEN-12){inst.b_fmt.imm_12}}, inst.b_fmt.imm_11,
                  inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm_31_12, 12'h000};
  assign imm_j = {{(`RV_XLEN-20){inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12,
                  inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

  // only add and sub survive from the OP group
  assign is_add_sub = (inst.r_fmt.funct3 == 3'b000) &&
                      ((inst.r_fmt.funct7 == 7'b000_0000) ||
                       (inst.r_fmt.funct7 == 7'b010_0000));
  assign is_ebreak  = (inst.i_fmt.funct3 == 3'b000) && (inst.i_fmt.imm_11_0 == 12'h001);

  always_comb begin
    ctrl.imm       = '0;
    ctrl.src_a     = rv_pkg::SRC_A_RS1;
    ctrl.src_b     = rv_pkg::SRC_B_IMM;
    ctrl.sub       = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jump   = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.wb_sel    = rv_pkg::WB_ALU;
    ctrl.reg_write = 1'b0;
    halt           = 1'b0;
    case (opcode)
      rv_pkg::OP: begin
        ctrl.src_b     = rv_pkg::SRC_B_RS2;
        ctrl.sub       = is_add_sub & inst.r_fmt.funct7[5];
        ctrl.reg_write = is_add_sub;
      end
      rv_pkg::OP_IMM: begin
        ctrl.imm       = imm_i;
        ctrl.reg_write = (inst.i_fmt.funct3 == 3'b000);  // addi only
      end
      rv_pkg::LUI: begin
        ctrl.src_a     = rv_pkg::SRC_A_ZERO;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::AUIPC: begin
        ctrl.src_a     = rv_pkg::SRC_A_PC;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::JAL: begin
        ctrl.src_a     = rv_pkg::SRC_A_PC;
        ctrl.imm       = imm_j;
        ctrl.is_jump   = 1'b1;
        ctrl.wb_sel    = rv_pkg::WB_LINK;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::JALR: begin
        ctrl.imm       = imm_i;
        ctrl.is_jump   = 1'b1;
        ctrl.wb_sel    = rv_pkg::WB_LINK;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::BRANCH: begin
        ctrl.src_a     = rv_pkg::SRC_A_PC;  // adder forms pc + offset
        ctrl.imm       = imm_b;
        ctrl.is_branch = 1'b1;
      end
      rv_pkg::LOAD: begin
        ctrl.imm       = imm_i;
        ctrl.mem_read  = 1'b1;
        ctrl.wb_sel    = rv_pkg::WB_LOAD;
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::STORE: begin
        ctrl.imm       = imm_s;
        ctrl.mem_write = 1'b1;
      end
      rv_pkg::SYSTEM: begin
        halt = is_ebreak;  // no writes of any kind here
      end
      default: begin
        // unknown opcode, treated as a nop
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module reg_file (
  input  wire logic                  clk,
  input  wire logic                  write_en,
  input  wire logic [`RV_REG_AW-1:0] waddr,
  input  wire logic [`RV_XLEN-1:0]   wdata,
  input  wire logic [`RV_REG_AW-1:0] raddr_a,
  input  wire logic [`RV_REG_AW-1:0] raddr_b,
  output logic      [`RV_XLEN-1:0]   rdata_a,
  output logic      [`RV_XLEN-1:0]   rdata_b
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (write_en && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: verilog/alu_branch.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module alu_branch (
  exec_ctrl_if.execute             ctrl,
  input  wire logic [`RV_XLEN-1:0] pc,
  input  wire logic [`RV_XLEN-1:0] rs1_data,
  input  wire logic [`RV_XLEN-1:0] rs2_data,
  output logic      [`RV_XLEN-1:0] result,
  output logic                     redirect,
  output logic      [`RV_XLEN-1:0] target
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] op_b_inv;
  logic                eq;
  logic                lt;
  logic                ltu;
  logic                taken;

  always_comb begin
    case (ctrl.src_a)
      rv_pkg::SRC_A_RS1: op_a = rs1_data;
      rv_pkg::SRC_A_PC:  op_a = pc;
      default:           op_a = '0;
    endcase
  end

  assign op_b = (ctrl.src_b == rv_pkg::SRC_B_RS2) ? rs2_data : ctrl.imm;

  // shared adder, subtract as invert plus carry in
  assign op_b_inv = op_b ^ {`RV_XLEN{ctrl.sub}};
  assign result   = op_a + op_b_inv + {{(`RV_XLEN-1){1'b0}}, ctrl.sub};

  // compare the registers directly, no overflow corner
  assign eq  = (rs1_data == rs2_data);
  assign lt  = ($signed(rs1_data) < $signed(rs2_data));
  assign ltu = (rs1_data < rs2_data);

  always_comb begin
    case (ctrl.funct3)
      3'b000:  taken = eq;    // beq
      3'b001:  taken = !eq;   // bne
      3'b100:  taken = lt;    // blt
      3'b101:  taken = !lt;   // bge
      3'b110:  taken = ltu;   // bltu
      3'b111:  taken = !ltu;  // bgeu
      default: taken = 1'b0;
    endcase
  end

  assign redirect = ctrl.is_jump | (ctrl.is_branch & taken);
  // bit 0 is already zero for jal and branches, jalr needs it cleared
  assign target   = {result[`RV_XLEN-1:1], 1'b0};

endmodule

`default_nettype wire

// File: verilog/load_store_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module load_store_unit (
  exec_ctrl_if.lsu                 ctrl,
  input  wire logic                reset,
  input  wire logic [`RV_XLEN-1:0] result,
  input  wire logic [`RV_XLEN-1:0] rs2_data,
  input  wire logic [`RV_XLEN-1:0] pc_plus4,
  output logic      [`RV_XLEN-1:0] dmem_addr,
  output logic      [`RV_XLEN-1:0] dmem_wdata,
  output logic      [3:0]          dmem_wmask,
  output logic                     dmem_read,
  output logic                     dmem_write,
  input  wire logic [`RV_XLEN-1:0] dmem_rdata,
  output logic      [`RV_XLEN-1:0] rd_data
);

  logic [1:0]          byte_off;
  logic [7:0]          ld_byte;
  logic [15:0]         ld_half;
  logic [`RV_XLEN-1:0] load_data;

  assign byte_off  = result[1:0];
  assign dmem_addr = {result[`RV_XLEN-1:2], 2'b00};  // word address to memory

  assign dmem_read  = !reset && ctrl.mem_read;
  assign dmem_write = !reset && ctrl.mem_write;

  // replicate the data so every lane carries it, the mask picks the lane
  always_comb begin
    case (ctrl.funct3[1:0])
      2'b00: begin  // sb
        dmem_wdata = {4{rs2_data[7:0]}};
        dmem_wmask = 4'b0001 << byte_off;
      end
      2'b01: begin  // sh
        dmem_wdata = {2{rs2_data[15:0]}};
        dmem_wmask = 4'b0011 << byte_off;
      end
      2'b10: begin  // sw
        dmem_wdata = rs2_data;
        dmem_wmask = 4'b1111;
      end
      default: begin
        dmem_wdata = rs2_data;
        dmem_wmask = 4'b0000;
      end
    endcase
  end

  assign ld_byte = dmem_rdata[{byte_off, 3'b000} +: 8];
  assign ld_half = dmem_rdata[{byte_off[1], 4'b0000} +: 16];

  always_comb begin
    case (ctrl.funct3)
      3'b000:  load_data = {{(`RV_XLEN-8){ld_byte[7]}}, ld_byte};     // lb
      3'b001:  load_data = {{(`RV_XLEN-16){ld_half[15]}}, ld_half};   // lh
      3'b100:  load_data = {{(`RV_XLEN-8){1'b0}}, ld_byte};           // lbu
      3'b101:  load_data = {{(`RV_XLEN-16){1'b0}}, ld_half};          // lhu
      default: load_data = dmem_rdata;                                // lw
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::WB_LINK: rd_data = pc_plus4;
      rv_pkg::WB_LOAD: rd_data = load_data;
      default:         rd_data = result;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core_top (
  input  wire logic                clk,
  input  wire logic                reset,
  output logic      [`RV_XLEN-1:0] pc,
  input  wire logic [`RV_XLEN-1:0] inst,
  output logic      [`RV_XLEN-1:0] dmem_addr,
  output logic      [`RV_XLEN-1:0] dmem_wdata,
  output logic      [3:0]          dmem_wmask,
  output logic                     dmem_read,
  output logic                     dmem_write,
  input  wire logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                     halt
);

  logic                  redirect;
  logic [`RV_XLEN-1:0]   target;
  logic [`RV_XLEN-1:0]   pc_plus4;
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_REG_AW-1:0] rd_addr;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   result;
  logic [`RV_XLEN-1:0]   rd_data;

  exec_ctrl_if ctrl ();

  pc_unit i_pc_unit (
    .clk      (clk),
    .reset    (reset),
    .halt     (halt),
    .redirect (redirect),
    .target   (target),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  inst_decoder i_inst_decoder (
    .inst     (inst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .halt     (halt),
    .ctrl     (ctrl)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .write_en (ctrl.reg_write),
    .waddr    (rd_addr),
    .wdata    (rd_data),
    .raddr_a  (rs1_addr),
    .raddr_b  (rs2_addr),
    .rdata_a  (rs1_data),
    .rdata_b  (rs2_data)
  );

  alu_branch i_alu_branch (
    .ctrl     (ctrl),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (result),
    .redirect (redirect),
    .target   (target)
  );

  load_store_unit i_load_store_unit (
    .ctrl       (ctrl),
    .reset      (reset),
    .result     (result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_rdata (dmem_rdata),
    .rd_data    (rd_data)
  );

endmodule

`default_nettype wire

// File: tb/rv_core_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module rv_core_checker (
  input wire logic                clk,
  input wire logic                reset,
  input wire logic [`RV_XLEN-1:0] pc,
  input wire logic [3:0]          dmem_wmask,
  input wire logic                dmem_read,
  input wire logic                dmem_write,
  input wire logic                halt
);

  // one access kind per cycle
  read_write_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(dmem_read && dmem_write)
  ) else $error("dmem_read and dmem_write high in the same cycle");

  store_has_mask: assert property (
    @(posedge clk) disable iff (reset) dmem_write |-> (dmem_wmask != 4'b0000)
  ) else $error("store issued with an empty byte mask");

  pc_word_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else $error("pc lost word alignment");

  // core parked on ebreak
  pc_frozen_on_halt: assert property (
    @(posedge clk) disable iff (reset) halt |=> $stable(pc)
  ) else $error("pc moved while halt was high");

endmodule

`default_nettype wire

// File: tb/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "rv_settings.svh"

module tb_rv_core;

  localparam int PROG_WORDS     = 256;
  localparam int DATA_WORDS     = 64;
  localparam int RESET_CYCLES   = 4;
  localparam int HALT_HOLD      = 8;  // cycles watched after ebreak
  localparam int TIMEOUT_CYCLES = 4 * PROG_WORDS + RESET_CYCLES;

  localparam logic [`RV_XLEN-1:0] PROG_BYTES = PROG_WORDS * 4;
  localparam logic [`RV_XLEN-1:0] DATA_BYTES = DATA_WORDS * 4;
  localparam logic [`RV_XLEN-1:0] DATA_BASE  = 32'h0001_0000;
  localparam logic [`RV_XLEN-1:0] EBREAK     = 32'h0010_0073;
  localparam logic [31:0]         SEED       = 32'hd4325c82;

  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  logic                clk = 1'b0;
  logic                reset;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] inst;
  logic [`RV_XLEN-1:0] dmem_addr;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic [3:0]          dmem_wmask;
  logic                dmem_read;
  logic                dmem_write;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                halt;

  logic [`RV_XLEN-1:0] prog       [PROG_WORDS];
  logic [`RV_XLEN-1:0] data_mem   [DATA_WORDS];  // memory seen by the DUT
  logic [`RV_XLEN-1:0] model_mem  [DATA_WORDS];
  logic [`RV_XLEN-1:0] model_regs [`RV_NUM_REGS];
  logic [`RV_XLEN-1:0] model_pc;
  logic [`RV_XLEN-1:0] pc_off;
  logic [`RV_XLEN-1:0] data_off;
  logic [`RV_XLEN-1:0] reset_inst;  // fetched while reset is high
  int                  cycle_count = 0;

  always #4 clk = ~clk;

  rv_core_top i_dut (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .inst       (inst),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .dmem_rdata (dmem_rdata),
    .halt       (halt)
  );

  bind rv_core_top rv_core_checker i_checker (
    .clk        (clk),
    .reset      (reset),
    .pc         (pc),
    .dmem_wmask (dmem_wmask),
    .dmem_read  (dmem_read),
    .dmem_write (dmem_write),
    .halt       (halt)
  );

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] lane_bits(input logic [3:0] mask);
    return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  mask);
    return (old_word & ~lane_bits(mask)) | (new_word & lane_bits(mask));
  endfunction

  // instruction and data served combinationally within the cycle
  assign pc_off   = pc - `RV_RESET_PC;
  assign data_off = dmem_addr - DATA_BASE;

  always_comb begin
    inst = EBREAK;  // everything outside the program
    if (reset) begin
      inst = reset_inst;
    end else if (pc_off < PROG_BYTES) begin
      inst = prog[pc_off[9:2]];
    end
  end

  always_comb begin
    dmem_rdata = fill_word(dmem_addr);
    if (data_off < DATA_BYTES) begin
      dmem_rdata = data_mem[data_off[7:2]];
    end
  end

  always @(posedge clk) begin
    if (dmem_write && (data_off < DATA_BYTES)) begin
      data_mem[data_off[7:2]] <= merge_bytes(data_mem[data_off[7:2]], dmem_wdata, dmem_wmask);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the core did not reach ebreak within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "simulation timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      $display("Fail %s exp=%h got=%h", name, exp, got);
      $display("=== FAIL ===");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [4:0] rd);
    return {f7, rs2, rs1, 3'b000, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // x1 is the data base and never a destination
  function automatic logic [4:0] pick_reg();
    logic [31:0] rnd;
    rnd = $urandom_range(15, 0);
    if (rnd == 32'd1) begin
      rnd = 32'd0;
    end
    return rnd[4:0];
  endfunction

  function automatic logic [19:0] pick_upper();
    logic [31:0] rnd;
    rnd = $urandom;
    case ($urandom_range(4, 0))
      0:       return 20'h80000;  // overflow corners
      1:       return 20'h7ffff;
      2:       return 20'hfffff;
      3:       return 20'h00000;
      default: return rnd[19:0];
    endcase
  endfunction

  // forward-only control flow, so every run reaches the ebreak past the end
  task automatic gen_program();
    int          idx;
    int          room;
    int          lim;
    int          r;
    logic [31:0] rnd;
    logic [31:0] off;
    logic [4:0]  rx;
    logic [2:0]  f3;
    prog[0] = enc_u(DATA_BASE[31:12], 5'd1, OPC_LUI);
    idx = 1;
    for (r = 2; r < 16; r++) begin
      rnd = $urandom;
      prog[idx]     = enc_u(pick_upper(), r[4:0], OPC_LUI);
      prog[idx + 1] = enc_i(rnd[11:0], r[4:0], 3'b000, r[4:0], OPC_OP_IMM);
      idx += 2;
    end
    while (idx < PROG_WORDS) begin
      room = PROG_WORDS - idx;
      lim  = (room < 8) ? room : 8;
      rnd  = $urandom;
      case ($urandom_range(10, 0))
        0: prog[idx] = enc_r(rnd[0] ? 7'h20 : 7'h00, pick_reg(), pick_reg(), pick_reg());
        1: prog[idx] = enc_i(rnd[11:0], pick_reg(), 3'b000, pick_reg(), OPC_OP_IMM);
        2: prog[idx] = enc_u(pick_upper(), pick_reg(), OPC_LUI);
        3: prog[idx] = enc_u(rnd[19:0], pick_reg(), OPC_AUIPC);
        4: begin
          off = $urandom_range(lim, 1) * 4;
          prog[idx] = enc_j(off[20:0], pick_reg());
        end
        5: begin
          if (room >= 2) begin  // auipc then jalr off the same base
            lim = (room - 2 < 6) ? room - 2 : 6;
            rnd = $urandom_range(15, 2);
            rx  = rnd[4:0];
            off = 8 + $urandom_range(lim, 0) * 4 + $urandom_range(1, 0);
            prog[idx] = enc_u(20'h00000, rx, OPC_AUIPC);
            idx++;
            prog[idx] = enc_i(off[11:0], rx, 3'b000, pick_reg(), OPC_JALR);
          end else begin
            prog[idx] = enc_i(rnd[11:0], pick_reg(), 3'b000, pick_reg(), OPC_OP_IMM);
          end
        end
        6: begin
          rnd = $urandom_range(5, 0);
          f3  = (rnd < 2) ? rnd[2:0] : rnd[2:0] + 3'd2;  // 0, 1, 4..7
          off = $urandom_range(lim, 1) * 4;
          prog[idx] = enc_b(off[12:0], pick_reg(), pick_reg(), f3);
        end
        7, 8: begin
          rnd = $urandom_range(4, 0);
          f3  = (rnd < 3) ? rnd[2:0] : rnd[2:0] + 3'd1;  // 0, 1, 2, 4, 5
          off = ($urandom_range(255, 0) >> f3[1:0]) << f3[1:0];
          prog[idx] = enc_i({4'd0, off[7:0]}, 5'd1, f3, pick_reg(), OPC_LOAD);
        end
        default: begin
          rnd = $urandom_range(2, 0);
          f3  = rnd[2:0];
          off = ($urandom_range(255, 0) >> f3[1:0]) << f3[1:0];
          prog[idx] = enc_s({4'd0, off[7:0]}, pick_reg(), 5'd1, f3);
        end
      endcase
      idx++;
    end
  endtask

  function automatic logic [31:0] model_fetch(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `RV_RESET_PC;
    if (off < PROG_BYTES) begin
      return prog[off[9:2]];
    end
    return EBREAK;
  endfunction

  // reference model steps one instruction per call and checks the DUT before updating
  task automatic step_and_check(output logic halted);
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] addr;
    logic [31:0] off;
    logic [31:0] word;
    logic [31:0] st_data;
    logic [31:0] wval;
    logic [31:0] next_pc;
    logic [3:0]  mask;
    logic        wen;
    logic        taken;
    logic        is_load;
    logic        is_store;
    ins      = model_fetch(model_pc);
    a        = model_regs[ins[19:15]];
    b        = model_regs[ins[24:20]];
    imm_i    = {{20{ins[31]}}, ins[31:20]};
    imm_s    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b    = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u    = {ins[31:12], 12'h000};
    imm_j    = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc  = model_pc + 32'd4;
    wval     = '0;
    addr     = '0;
    st_data  = '0;
    mask     = '0;
    wen      = 1'b0;
    taken    = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    halted   = (ins == EBREAK);
    case (ins[6:0])
      OPC_OP: begin
        wval = ins[30] ? a - b : a + b;
        wen  = 1'b1;
      end
      OPC_OP_IMM: begin
        wval = a + imm_i;
        wen  = 1'b1;
      end
      OPC_LUI: begin
        wval = imm_u;
        wen  = 1'b1;
      end
      OPC_AUIPC: begin
        wval = model_pc + imm_u;
        wen  = 1'b1;
      end
      OPC_JAL: begin
        wval    = model_pc + 32'd4;
        wen     = 1'b1;
        next_pc = model_pc + imm_j;
      end
      OPC_JALR: begin
        wval    = model_pc + 32'd4;
        wen     = 1'b1;
        next_pc = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (ins[14:12])
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          3'b111:  taken = (a >= b);
          default: taken = 1'b0;
        endcase
        if (taken) begin
          next_pc = model_pc + imm_b;
        end
      end
      OPC_LOAD: begin
        addr    = a + imm_i;
        off     = addr - DATA_BASE;
        is_load = 1'b1;
        wen     = 1'b1;
        word    = model_mem[off[7:2]] >> {addr[1:0], 3'b000};
        case (ins[14:12])
          3'b000:  wval = {{24{word[7]}}, word[7:0]};
          3'b001:  wval = {{16{word[15]}}, word[15:0]};
          3'b100:  wval = {24'd0, word[7:0]};
          3'b101:  wval = {16'd0, word[15:0]};
          default: wval = word;
        endcase
      end
      OPC_STORE: begin
        addr     = a + imm_s;
        is_store = 1'b1;
        st_data  = b << {addr[1:0], 3'b000};
        case (ins[13:12])
          2'b00:   mask = 4'b0001 << addr[1:0];
          2'b01:   mask = 4'b0011 << addr[1:0];
          default: mask = 4'b1111;
        endcase
      end
      OPC_SYSTEM: begin
        if (halted) begin
          next_pc = model_pc;
        end
      end
      default: begin
      end
    endcase

    check_value("pc", model_pc, pc);
    check_value("halt", {31'd0, halted}, {31'd0, halt});
    check_value("dmem_read", {31'd0, is_load}, {31'd0, dmem_read});
    check_value("dmem_write", {31'd0, is_store}, {31'd0, dmem_write});
    if (is_load || is_store) begin
      check_value("dmem_addr", {addr[31:2], 2'b00}, dmem_addr);
    end
    if (is_store) begin
      off = addr - DATA_BASE;
      check_value("dmem_wmask", {28'd0, mask}, {28'd0, dmem_wmask});
      check_value("dmem_wdata", st_data & lane_bits(mask), dmem_wdata & lane_bits(mask));
      model_mem[off[7:2]] = merge_bytes(model_mem[off[7:2]], st_data, mask);
    end
    if (wen && (ins[11:7] != 5'd0)) begin
      model_regs[ins[11:7]] = wval;
    end
    model_pc = next_pc;
  endtask

  initial begin
    logic [31:0] seed_ret;
    logic [31:0] word_addr;
    logic        halted;
    int          halt_cycles;
    int          i;
    reset      = 1'b1;
    reset_inst = enc_s(12'h000, 5'd2, 5'd1, 3'b010);  // sw fetched during reset
    seed_ret   = $urandom(SEED);
    gen_program();
    for (i = 0; i < DATA_WORDS; i++) begin
      word_addr    = DATA_BASE + i * 4;
      data_mem[i]  = fill_word(word_addr);
      model_mem[i] = fill_word(word_addr);
    end
    for (i = 0; i < `RV_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    model_pc = `RV_RESET_PC;

    repeat (RESET_CYCLES - 2) @(posedge clk);
    @(negedge clk);
    check_value("dmem_write", 32'd0, {31'd0, dmem_write});  // held off in reset
    @(posedge clk);
    reset_inst <= enc_i(12'h000, 5'd1, 3'b010, 5'd0, OPC_LOAD);  // lw into x0
    @(negedge clk);
    check_value("dmem_read", 32'd0, {31'd0, dmem_read});
    @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    check_value("pc", `RV_RESET_PC, pc);
    check_value("dmem_write", 32'd0, {31'd0, dmem_write});
    check_value("halt", 32'd0, {31'd0, halt});

    halt_cycles = 0;
    while (halt_cycles < HALT_HOLD) begin
      step_and_check(halted);
      if (halted) begin
        halt_cycles++;
      end
      @(negedge clk);
    end

    // memory must match after the core parked
    for (i = 0; i < DATA_WORDS; i++) begin
      check_value("data_mem", model_mem[i], data_mem[i]);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/exec_ctrl_if.sv
verilog/pc_unit.sv
verilog/inst_decoder.sv
verilog/reg_file.sv
verilog/alu_branch.sv
verilog/load_store_unit.sv
verilog/rv_core_top.sv
tb/rv_core_checker.sv
tb/tb_rv_core.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_rv_core
LINT_TOP   ?= rv_core_top
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

SOURCES := $(FILELIST) $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
